/* tb.f */
hdl/eth_pkg.sv
hdl/frame_if.sv
hdl/eth_ctrl.sv
hdl/arp_gen.sv
hdl/udp_gen.sv
hdl/tx_mux.sv
hdl/eth_tx_top.sv
test/tb_clk.sv
test/eth_tx_assertions.sv
test/eth_tx_tb.sv

/* Bender.yml */
package:
  name: eth_tx

sources:
  - hdl/eth_pkg.sv
  - hdl/frame_if.sv
  - hdl/eth_ctrl.sv
  - hdl/arp_gen.sv
  - hdl/udp_gen.sv
  - hdl/tx_mux.sv
  - hdl/eth_tx_top.sv
  - target: test
    files:
      - test/tb_clk.sv
      - test/eth_tx_assertions.sv
      - test/eth_tx_tb.sv

/* test/eth_tx_tb.sv */
`timescale 1ns/1ps

module eth_tx_tb import eth_pkg::*; ();

  typedef enum {OP_CFG, OP_ARP, OP_UDP, OP_BOTH, OP_UDP_ARP} op_e;

  typedef struct {
    string      name;
    op_e        op;
    ipv4_t      ip;    // Config address or ARP target
    port_t      sport;
    port_t      dport;
    int         len;   // UDP payload bytes
    logic [7:0] seed;
    bit         stall; // Random credit stalls
  } row_t;

  localparam ipv4_t     DEV_IP      = 32'hc0a8_0164;
  localparam ipv4_t     WRONG_IP    = 32'hc0a8_0163;
  localparam ipv4_t     PEER_IP     = 32'hc0a8_0105;
  localparam mac_addr_t PEER_MAC    = 48'h02_aa_bb_cc_dd_ee;
  localparam int        NROWS       = 12;
  localparam int        QUIET       = 60;                 // Idle window, no frame expected
  localparam int        CYCLE_LIMIT = 4 * 60 * NROWS + 16; // Rows plus reset

  logic                     clk;
  logic                     rst;
  logic                     cfg_valid;
  ipv4_t                    cfg_ipv4;
  logic                     arp_req;
  mac_addr_t                arp_sha;
  ipv4_t                    arp_spa;
  ipv4_t                    arp_tpa;
  logic                     udp_req;
  mac_addr_t                udp_dst_mac;
  ipv4_t                    udp_dst_ipv4;
  port_t                    udp_src_port;
  port_t                    udp_dst_port;
  logic [PAYLOAD_LEN_W-1:0] udp_len;
  logic [7:0]               udp_seed;
  logic                     tx_credit;
  logic                     ready;
  logic                     udp_busy;
  logic [7:0]               tx_dat;
  logic                     tx_val;
  logic                     tx_sof;
  logic                     tx_eof;

  logic [7:0] exp_bytes[$];
  logic [7:0] rx_bytes[$];
  int         exp_lens[$];
  int         rx_lens[$];
  string      cur_name = "reset";
  bit         stall_mode;
  bit         in_frame;
  bit         model_ready;
  ipv4_t      model_ip;
  int         sent;      // tx_val cycles seen
  int         returned;  // Credits handed back
  int         cur_len;
  int         cycle_cnt;
  row_t       rows [NROWS];

  tb_clk clk_gen (.clk(clk), .rst(rst));

  eth_tx_top uut (
    .clk(clk), .rst(rst), .cfg_valid(cfg_valid), .cfg_ipv4(cfg_ipv4),
    .arp_req(arp_req), .arp_sha(arp_sha), .arp_spa(arp_spa), .arp_tpa(arp_tpa),
    .udp_req(udp_req), .udp_dst_mac(udp_dst_mac), .udp_dst_ipv4(udp_dst_ipv4),
    .udp_src_port(udp_src_port), .udp_dst_port(udp_dst_port), .udp_len(udp_len),
    .udp_seed(udp_seed), .tx_credit(tx_credit), .ready(ready), .udp_busy(udp_busy),
    .tx_dat(tx_dat), .tx_val(tx_val), .tx_sof(tx_sof), .tx_eof(tx_eof)
  );

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  ////////////////////
  // Frame model
  ////////////////////
  function automatic void put_field(ref logic [7:0] q[$], input logic [63:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) q.push_back(v[8*i +: 8]); // Network order
  endfunction

  function automatic logic [15:0] ip_checksum(input logic [7:0] h[$]);
    logic [31:0] sum;
    sum = 0;
    for (int i = 0; i < h.size(); i += 2) sum += {h[i], h[i+1]};
    while (sum[31:16] != 0) sum = sum[15:0] + sum[31:16]; // End-around carry
    return ~sum[15:0];
  endfunction

  function automatic void finish_frame(ref logic [7:0] f[$]);
    while (f.size() < MIN_FRAME) f.push_back(8'h00); // Zero pad
    foreach (f[i]) exp_bytes.push_back(f[i]);
    exp_lens.push_back(f.size());
  endfunction

  function automatic void push_arp_frame(input mac_addr_t sha, input ipv4_t spa, input ipv4_t dev);
    logic [7:0] f[$];
    put_field(f, sha, 6);                      // Back to the requester
    put_field(f, DEV_MAC, 6);
    put_field(f, 16'h0806, 2);
    put_field(f, 64'h0001_0800_0604_0002, 8); // HTYPE, PTYPE, sizes, reply
    put_field(f, DEV_MAC, 6);
    put_field(f, dev, 4);
    put_field(f, sha, 6);
    put_field(f, spa, 4);
    finish_frame(f);
  endfunction

  function automatic void push_udp_frame(input row_t r, input ipv4_t dev);
    logic [7:0]  f[$];
    logic [7:0]  h[$];
    logic [15:0] csum;
    put_field(h, 16'h4500, 2);
    put_field(h, 28 + r.len, 2);               // Total length
    put_field(h, 32'h0, 4);                    // ID, flags, fragment
    put_field(h, 32'h4011_0000, 4);            // TTL 64, UDP, checksum slot
    put_field(h, dev, 4);
    put_field(h, PEER_IP, 4);
    csum  = ip_checksum(h);
    h[10] = csum[15:8];
    h[11] = csum[7:0];
    put_field(f, PEER_MAC, 6);
    put_field(f, DEV_MAC, 6);
    put_field(f, 16'h0800, 2);
    foreach (h[i]) f.push_back(h[i]);
    put_field(f, {r.sport, r.dport}, 4);
    put_field(f, 8 + r.len, 2);                // UDP length, zero checksum next
    put_field(f, 16'h0000, 2);
    for (int k = 0; k < r.len; k++) f.push_back(8'(r.seed + k)); // Counting payload
    finish_frame(f);
  endfunction

  function automatic void expect_row(input row_t r);
    bit arp_ok;
    arp_ok = model_ready && (r.ip == model_ip);
    if ((r.op == OP_ARP || r.op == OP_BOTH) && arp_ok) push_arp_frame(PEER_MAC, PEER_IP, model_ip);
    if (r.op inside {OP_UDP, OP_BOTH, OP_UDP_ARP} && model_ready) push_udp_frame(r, model_ip);
    if (r.op == OP_UDP_ARP && arp_ok) push_arp_frame(PEER_MAC, PEER_IP, model_ip); // After UDP
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////
  task automatic pulse_req(input bit do_arp, input bit do_udp);
    arp_req = do_arp;
    udp_req = do_udp;
    @(negedge clk);
    arp_req = 1'b0;
    udp_req = 1'b0;
  endtask

  task automatic run_row(input row_t r);
    cur_name   = r.name;
    stall_mode = r.stall;
    exp_bytes.delete();
    exp_lens.delete();
    rx_bytes.delete();
    rx_lens.delete();
    expect_row(r);
    arp_tpa      = r.ip;
    udp_src_port = r.sport;
    udp_dst_port = r.dport;
    udp_len      = PAYLOAD_LEN_W'(r.len);
    udp_seed     = r.seed;
    check_val({r.name, "/ready"}, model_ready, ready);
    check_val({r.name, "/busy"}, !model_ready, udp_busy); // Busy until configured
    case (r.op)
      OP_CFG: begin
        cfg_ipv4  = r.ip;
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid   = 1'b0;
        model_ready = 1'b1;
        model_ip    = r.ip;
        check_val({r.name, "/ready_after"}, 1, ready); // One cycle after the strobe
        check_val({r.name, "/busy_after"}, 0, udp_busy);
      end
      OP_ARP:  pulse_req(1'b1, 1'b0);
      OP_UDP:  pulse_req(1'b0, 1'b1);
      OP_BOTH: pulse_req(1'b1, 1'b1);
      OP_UDP_ARP: begin
        pulse_req(1'b0, 1'b1);
        while (!in_frame) @(negedge clk); // UDP frame under way
        check_val({r.name, "/busy_in_frame"}, 1, udp_busy); // Held until eof
        pulse_req(1'b1, 1'b0);
      end
      default: ;
    endcase
    if (exp_lens.size() == 0) repeat (QUIET) @(negedge clk);
    else while (rx_lens.size() < exp_lens.size()) @(negedge clk);
    repeat (4) @(negedge clk); // Room for stray bytes
    check_val({r.name, "/frames"}, exp_lens.size(), rx_lens.size());
    check_val({r.name, "/bytes"}, exp_bytes.size(), rx_bytes.size());
    foreach (exp_lens[i]) check_val($sformatf("%s/len%0d", r.name, i), exp_lens[i], rx_lens[i]);
    foreach (exp_bytes[i]) check_val($sformatf("%s/byte%0d", r.name, i), exp_bytes[i], rx_bytes[i]);
  endtask

  ////////////////////
  // Collector and credit return
  ////////////////////
  initial begin
    void'($urandom(32'hceb0)); // Single seed for the run
    forever begin
      @(negedge clk);
      if (rst) begin
        tx_credit = 1'b0;
        sent      = 0;
        returned  = 0;
        cur_len   = 0;
        in_frame  = 1'b0;
      end else begin
        if (tx_val) begin
          check_val({cur_name, "/sof"}, !in_frame, tx_sof); // First byte only
          rx_bytes.push_back(tx_dat);
          sent++;
          cur_len++;
          in_frame = !tx_eof;
          if (tx_eof) begin
            rx_lens.push_back(cur_len);
            cur_len = 0;
          end
        end
        check_val({cur_name, "/credit_bound"}, 1, sent <= TX_CREDITS + returned);
        // Never return more than was spent
        tx_credit = (sent > returned) && (!stall_mode || $urandom_range(1, 0) == 1);
        if (tx_credit) returned++;
        if (uut.eth_tx_assertions_inst.fail_cnt != 0) begin
          $display("Assertion failure during %s", cur_name);
          $display("ERRORS FOUND");
          $fatal(1);
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, expected frames did not arrive", cycle_cnt);
    $display("ERRORS FOUND");
    $fatal(1);
  end

  initial begin
    cfg_valid    = 1'b0;
    cfg_ipv4     = '0;
    arp_req      = 1'b0;
    arp_sha      = PEER_MAC;
    arp_spa      = PEER_IP;
    arp_tpa      = '0;
    udp_req      = 1'b0;
    udp_dst_mac  = PEER_MAC;
    udp_dst_ipv4 = PEER_IP;
    udp_src_port = '0;
    udp_dst_port = '0;
    udp_len      = '0;
    udp_seed     = '0;
    tx_credit    = 1'b0;
    model_ready  = 1'b0;
    model_ip     = '0;
    rows = '{
      '{"arp_unconfigured",   OP_ARP,     32'h0,    16'd0,    16'd0,    0,  8'h00, 1'b0},
      '{"udp_unconfigured",   OP_UDP,     DEV_IP,   16'd5000, 16'd7,    4,  8'h00, 1'b0},
      '{"config",             OP_CFG,     DEV_IP,   16'd0,    16'd0,    0,  8'h00, 1'b0},
      '{"arp_reply",          OP_ARP,     DEV_IP,   16'd0,    16'd0,    0,  8'h00, 1'b0},
      '{"arp_wrong_ip",       OP_ARP,     WRONG_IP, 16'd0,    16'd0,    0,  8'h00, 1'b0},
      '{"udp_len1",           OP_UDP,     DEV_IP,   16'd5000, 16'd7,    1,  8'h10, 1'b0},
      '{"udp_len18",          OP_UDP,     DEV_IP,   16'd5001, 16'd9,    18, 8'hf5, 1'b0},
      '{"udp_len_max",        OP_UDP,     DEV_IP,   16'hc000, 16'd53,   MAX_PAYLOAD, 8'he8, 1'b0},
      '{"arp_udp_same_cycle", OP_BOTH,    DEV_IP,   16'd1234, 16'd4321, 5,  8'h33, 1'b0},
      '{"arp_during_udp",     OP_UDP_ARP, DEV_IP,   16'd2000, 16'd2001, 20, 8'h80, 1'b0},
      '{"udp_credit_stall",   OP_UDP,     DEV_IP,   16'd3000, 16'd3001, MAX_PAYLOAD, 8'h01, 1'b1},
      '{"both_credit_stall",  OP_BOTH,    DEV_IP,   16'd4000, 16'd4001, 7,  8'hfe, 1'b1}
    };
    while (rst !== 1'b0) @(negedge clk);
    repeat (2) @(negedge clk);
    foreach (rows[i]) run_row(rows[i]);
    if (uut.eth_tx_assertions_inst.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

endmodule

/* test/eth_tx_assertions.sv */
`timescale 1ns/1ps

module eth_tx_assertions import eth_pkg::*; (
  input logic                clk,
  input logic                rst,
  input src_sel_e            sel,
  input logic [CREDIT_W-1:0] credits,
  input logic                tx_val,
  input logic                tx_sof,
  input logic                tx_eof
);

  int fail_cnt = 0; // Failed assertion count, read from the testbench

  // Empty credit count keeps the next output cycle idle
  a_credit: assert property (@(posedge clk) disable iff (rst) credits == '0 |=> !tx_val)
    else begin
      $error("byte sent with zero credits");
      fail_cnt++;
    end

  // Source released only to SRC_NONE, together with its eof
  a_sel_hold: assert property (@(posedge clk) disable iff (rst)
    ($past(sel) != SRC_NONE && sel != $past(sel)) |-> (sel == SRC_NONE && tx_eof))
    else begin
      $error("sel changed inside a frame");
      fail_cnt++;
    end

  a_sof_val: assert property (@(posedge clk) disable iff (rst) tx_sof |-> tx_val)
    else begin
      $error("tx_sof without tx_val");
      fail_cnt++;
    end

  a_eof_val: assert property (@(posedge clk) disable iff (rst) tx_eof |-> tx_val)
    else begin
      $error("tx_eof without tx_val");
      fail_cnt++;
    end

endmodule

// Top scope reaches both the credit counter and the mux outputs
bind eth_tx_top eth_tx_assertions eth_tx_assertions_inst (
  .clk     (clk),
  .rst     (rst),
  .sel     (sel),
  .credits (eth_ctrl_inst.credits),
  .tx_val  (tx_val),
  .tx_sof  (tx_sof),
  .tx_eof  (tx_eof)
);

/* test/tb_clk.sv */
`timescale 1ns/1ps

module tb_clk (
  output logic clk,
  output logic rst
);

  localparam int HALF_NS    = 20; // 40 ns period
  localparam int RST_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk) rst = 1'b0; // Release away from the active edge
  end

endmodule

/* hdl/eth_tx_top.sv */
`timescale 1ns/1ps

module eth_tx_top import eth_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cfg_valid,
  input  ipv4_t                    cfg_ipv4,
  input  logic                     arp_req,
  input  mac_addr_t                arp_sha,
  input  ipv4_t                    arp_spa,
  input  ipv4_t                    arp_tpa,
  input  logic                     udp_req,
  input  mac_addr_t                udp_dst_mac,
  input  ipv4_t                    udp_dst_ipv4,
  input  port_t                    udp_src_port,
  input  port_t                    udp_dst_port,
  input  logic [PAYLOAD_LEN_W-1:0] udp_len,
  input  logic [7:0]               udp_seed,
  input  logic                     tx_credit,
  output logic                     ready,
  output logic                     udp_busy,
  output logic [7:0]               tx_dat,
  output logic                     tx_val,
  output logic                     tx_sof,
  output logic                     tx_eof
);

  frame_if arp_fr ();
  frame_if udp_fr ();

  ipv4_t    dev_ipv4;
  logic     arp_start;
  logic     udp_start;
  src_sel_e sel;
  logic     shift;

  ////////////////////
  // Control
  ////////////////////
  eth_ctrl eth_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .cfg_valid (cfg_valid),
    .cfg_ipv4  (cfg_ipv4),
    .arp_req   (arp_req),
    .arp_tpa   (arp_tpa),
    .udp_req   (udp_req),
    .tx_credit (tx_credit),
    .arp_val   (arp_fr.val),
    .arp_eof   (arp_fr.eof),
    .udp_val   (udp_fr.val),
    .udp_eof   (udp_fr.eof),
    .dev_ipv4  (dev_ipv4),
    .ready     (ready),
    .udp_busy  (udp_busy),
    .arp_start (arp_start),
    .udp_start (udp_start),
    .arp_adv   (arp_fr.adv), // Sink-side strobe into each stream
    .udp_adv   (udp_fr.adv),
    .sel       (sel),
    .shift     (shift)
  );

  ////////////////////
  // Frame sources
  ////////////////////
  arp_gen arp_gen_inst (
    .clk      (clk),
    .rst      (rst),
    .start    (arp_start),
    .req_sha  (arp_sha),
    .req_spa  (arp_spa),
    .dev_ipv4 (dev_ipv4),
    .fr       (arp_fr)
  );

  udp_gen udp_gen_inst (
    .clk      (clk),
    .rst      (rst),
    .start    (udp_start),
    .dst_mac  (udp_dst_mac),
    .dst_ipv4 (udp_dst_ipv4),
    .src_port (udp_src_port),
    .dst_port (udp_dst_port),
    .len      (udp_len),
    .seed     (udp_seed),
    .dev_ipv4 (dev_ipv4),
    .fr       (udp_fr)
  );

  ////////////////////
  // Output stage
  ////////////////////
  tx_mux tx_mux_inst (
    .clk    (clk),
    .rst    (rst),
    .sel    (sel),
    .shift  (shift),
    .arp    (arp_fr),
    .udp    (udp_fr),
    .tx_dat (tx_dat),
    .tx_val (tx_val),
    .tx_sof (tx_sof),
    .tx_eof (tx_eof)
  );

endmodule

/* hdl/tx_mux.sv */
`timescale 1ns/1ps

module tx_mux import eth_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  src_sel_e   sel,
  input  logic       shift,
  frame_if.mux       arp,
  frame_if.mux       udp,
  output logic [7:0] tx_dat,
  output logic       tx_val,
  output logic       tx_sof,
  output logic       tx_eof
);

  logic [7:0] sel_dat;
  logic       sel_sof;
  logic       sel_eof;

  // Source stays fixed for a whole frame
  assign sel_dat = (sel == SRC_ARP) ? arp.dat : udp.dat;
  assign sel_sof = (sel == SRC_ARP) ? arp.sof : udp.sof;
  assign sel_eof = (sel == SRC_ARP) ? arp.eof : udp.eof;

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_val <= 1'b0;
      tx_sof <= 1'b0;
      tx_eof <= 1'b0;
    end else begin
      tx_val <= shift;
      tx_sof <= shift && sel_sof; // Markers only with a byte
      tx_eof <= shift && sel_eof;
    end
  end

  always_ff @(posedge clk) begin
    if (shift) tx_dat <= sel_dat;
  end

endmodule

/* hdl/udp_gen.sv */
`timescale 1ns/1ps

module udp_gen import eth_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  mac_addr_t                dst_mac,
  input  ipv4_t                    dst_ipv4,
  input  port_t                    src_port,
  input  port_t                    dst_port,
  input  logic [PAYLOAD_LEN_W-1:0] len,
  input  logic [7:0]               seed,
  input  ipv4_t                    dev_ipv4,
  frame_if.gen                     fr
);

  gen_state_e               state;
  logic [1:0]               fold_cnt;  // Checksum steps left
  logic [6:0]               idx;       // Byte index in the frame
  logic [6:0]               frame_end; // Index of the eof byte
  mac_addr_t                dst_mac_r;
  ipv4_t                    dst_ipv4_r;
  port_t                    src_port_r;
  port_t                    dst_port_r;
  logic [PAYLOAD_LEN_W-1:0] len_r;
  logic [7:0]               seed_r;
  logic [15:0]              ip_len;
  logic [15:0]              udp_len;
  logic [19:0]              word_sum;  // Room for carries of nine words
  logic [19:0]              sum_r;
  logic [16:0]              fold1;
  logic [15:0]              csum_r;
  logic [0:HDR_LEN-1][7:0]  hdr;

  assign ip_len  = 16'd28 + len_r;
  assign udp_len = 16'd8 + len_r;

  ////////////////////
  // IPv4 checksum
  ////////////////////
  assign word_sum = 20'h04500 + ip_len + {IP_TTL, IP_PROTO_UDP}
                  + dev_ipv4[31:16] + dev_ipv4[15:0]
                  + dst_ipv4_r[31:16] + dst_ipv4_r[15:0]; // ID and frag words are zero
  assign fold1    = sum_r[15:0] + sum_r[19:16];           // First carry fold

  assign hdr = {
    dst_mac_r, DEV_MAC, ETHERTYPE_IPV4,                   // Ethernet
    16'h4500, ip_len, 16'h0000, 16'h0000,                 // Ver/IHL, len, ID, frag
    IP_TTL, IP_PROTO_UDP, csum_r, dev_ipv4, dst_ipv4_r,   // Rest of IPv4
    src_port_r, dst_port_r, udp_len, 16'h0000            // UDP, no checksum
  };

  // Short payloads pad out to MIN_FRAME
  assign frame_end = (len_r < 7'(MIN_FRAME - HDR_LEN)) ? 7'(MIN_FRAME - 1)
                                                      : 7'(HDR_LEN - 1) + len_r;

  assign fr.val = (state == GEN_SEND) && (fold_cnt == '0); // Hold off until checksum done
  assign fr.sof = (idx == '0);
  assign fr.eof = (idx == frame_end);

  always_comb begin
    if (idx < 7'(HDR_LEN))              fr.dat = hdr[idx];
    else if (idx < 7'(HDR_LEN) + len_r) fr.dat = seed_r + 8'(idx - 7'(HDR_LEN)); // Count
    else                                fr.dat = 8'h00;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= GEN_IDLE;
      fold_cnt <= '0;
      idx      <= '0;
    end else begin
      case (state)
        GEN_IDLE: if (start) begin
          state    <= GEN_SEND;
          fold_cnt <= 2'd2;
          idx      <= '0;
        end
        GEN_SEND: begin
          if (fold_cnt != '0) begin
            fold_cnt <= fold_cnt - 1'b1;
          end else if (fr.adv) begin
            if (fr.eof) state <= GEN_IDLE;
            else        idx   <= idx + 1'b1;
          end
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

  // Request fields and checksum pipeline
  always_ff @(posedge clk) begin
    if (state == GEN_IDLE && start) begin
      dst_mac_r  <= dst_mac;
      dst_ipv4_r <= dst_ipv4;
      src_port_r <= src_port;
      dst_port_r <= dst_port;
      len_r      <= (len > PAYLOAD_LEN_W'(MAX_PAYLOAD)) ? PAYLOAD_LEN_W'(MAX_PAYLOAD) : len;
      seed_r     <= seed;
    end
    if (fold_cnt == 2'd2) sum_r  <= word_sum;
    if (fold_cnt == 2'd1) csum_r <= ~(fold1[15:0] + fold1[16]); // Final fold, invert
  end

endmodule

/* hdl/arp_gen.sv */
`timescale 1ns/1ps

module arp_gen import eth_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  mac_addr_t req_sha,
  input  ipv4_t     req_spa,
  input  ipv4_t     dev_ipv4,
  frame_if.gen      fr
);

  gen_state_e              state;
  logic [5:0]              idx;   // Byte index in the reply
  mac_addr_t               sha_r; // Requester MAC
  ipv4_t                   spa_r; // Requester IP
  logic [0:HDR_LEN-1][7:0] hdr;

  // Ethernet header followed by the ARP reply body
  assign hdr = {
    sha_r, DEV_MAC, ETHERTYPE_ARP,     // Ethernet
    16'h0001, ETHERTYPE_IPV4,          // HTYPE, PTYPE
    8'd6, 8'd4, 16'h0002,              // HLEN, PLEN, reply
    DEV_MAC, dev_ipv4,                 // Sender
    sha_r, spa_r                       // Target
  };

  assign fr.val = (state == GEN_SEND);
  assign fr.sof = (idx == '0);
  assign fr.eof = (idx == 6'(MIN_FRAME - 1));
  assign fr.dat = (idx < 6'(HDR_LEN)) ? hdr[idx] : 8'h00; // Zero pad to MIN_FRAME

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= GEN_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        GEN_IDLE: if (start) begin
          state <= GEN_SEND;
          idx   <= '0;
        end
        GEN_SEND: if (fr.adv) begin
          if (fr.eof) state <= GEN_IDLE; // Last byte taken
          else        idx   <= idx + 1'b1;
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == GEN_IDLE && start) begin
      sha_r <= req_sha;
      spa_r <= req_spa;
    end
  end

endmodule

/* hdl/eth_ctrl.sv */
`timescale 1ns/1ps

module eth_ctrl import eth_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     cfg_valid,
  input  ipv4_t    cfg_ipv4,
  input  logic     arp_req,
  input  ipv4_t    arp_tpa,
  input  logic     udp_req,
  input  logic     tx_credit,
  input  logic     arp_val,
  input  logic     arp_eof,
  input  logic     udp_val,
  input  logic     udp_eof,
  output ipv4_t    dev_ipv4,
  output logic     ready,
  output logic     udp_busy,
  output logic     arp_start,
  output logic     udp_start,
  output logic     arp_adv,
  output logic     udp_adv,
  output src_sel_e sel,
  output logic     shift
);

  logic                arp_pend;  // ARP reply waiting for the output
  logic                udp_pend;  // UDP frame waiting for the output
  logic                udp_run;   // UDP accepted, eof not yet out
  logic [CREDIT_W-1:0] credits;   // Output credit count
  logic                src_val;
  logic                src_eof;
  logic                arp_ok;
  logic                udp_ok;

  ////////////////////
  // Request gating
  ////////////////////
  assign arp_ok   = ready && arp_req && (arp_tpa == dev_ipv4) && !arp_pend && (sel != SRC_ARP);
  assign udp_ok   = udp_req && !udp_busy;
  assign udp_busy = !ready || udp_run; // Busy also means not configured

  ////////////////////
  // Byte movement
  ////////////////////
  assign src_val = ((sel == SRC_ARP) && arp_val) || ((sel == SRC_UDP) && udp_val);
  assign src_eof = (sel == SRC_ARP) ? arp_eof : udp_eof;
  assign shift   = src_val && (credits != '0); // Hold at zero credit
  assign arp_adv = shift && (sel == SRC_ARP);
  assign udp_adv = shift && (sel == SRC_UDP);

  // Device address, fixed once configured
  always_ff @(posedge clk) begin
    if (rst) begin
      dev_ipv4 <= '0;
      ready    <= 1'b0;
    end else if (cfg_valid) begin
      dev_ipv4 <= cfg_ipv4;
      ready    <= 1'b1;
    end
  end

  // Pending flags and frame-level arbitration
  always_ff @(posedge clk) begin
    if (rst) begin
      arp_pend  <= 1'b0;
      udp_pend  <= 1'b0;
      udp_run   <= 1'b0;
      arp_start <= 1'b0;
      udp_start <= 1'b0;
      sel       <= SRC_NONE;
    end else begin
      arp_start <= 1'b0;
      udp_start <= 1'b0;
      if (arp_ok) arp_pend <= 1'b1;
      if (udp_ok) begin
        udp_pend <= 1'b1;
        udp_run  <= 1'b1;
      end
      if (sel == SRC_NONE) begin
        if (arp_pend) begin // ARP first at the boundary
          arp_pend  <= 1'b0;
          arp_start <= 1'b1;
          sel       <= SRC_ARP;
        end else if (udp_pend) begin
          udp_pend  <= 1'b0;
          udp_start <= 1'b1;
          sel       <= SRC_UDP;
        end
      end else if (shift && src_eof) begin
        if (sel == SRC_UDP) udp_run <= 1'b0; // eof leaves the mux next cycle
        sel <= SRC_NONE;
      end
    end
  end

  // Credit counter, spend on shift and refill on tx_credit
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CREDIT_W'(TX_CREDITS);
    end else begin
      case ({tx_credit, shift})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits; // Both or neither, no change
      endcase
    end
  end

endmodule

/* hdl/frame_if.sv */
`timescale 1ns/1ps

interface frame_if;

  logic [7:0] dat; // Current frame byte
  logic       val; // Byte on dat is valid
  logic       sof; // First byte of frame
  logic       eof; // Last byte of frame
  logic       adv; // Sink took the byte, step on

  modport gen (
    output dat, val, sof, eof,
    input  adv
  );

  // Sink side sees the stream only, adv comes from control
  modport mux (
    input dat, val, sof, eof
  );

endinterface

/* hdl/eth_pkg.sv */
package eth_pkg;

  ////////////////////
  // Address types
  ////////////////////
  typedef logic [47:0] mac_addr_t; // Ethernet MAC
  typedef logic [31:0] ipv4_t;     // IPv4 address
  typedef logic [15:0] port_t;     // UDP port

  ////////////////////
  // Enums
  ////////////////////
  typedef enum logic [1:0] {
    SRC_NONE, // Output idle, frame boundary
    SRC_ARP,  // ARP reply owns the output
    SRC_UDP   // UDP frame owns the output
  } src_sel_e;

  typedef enum logic {
    GEN_IDLE, // Waiting for start
    GEN_SEND  // Stepping through frame bytes
  } gen_state_e;

  ////////////////////
  // Constants
  ////////////////////
  localparam mac_addr_t   DEV_MAC        = 48'h02_00_5e_10_20_30; // Locally administered
  localparam int          TX_CREDITS     = 8;                     // Credits after reset, also max
  localparam int          CREDIT_W       = $clog2(TX_CREDITS + 1);
  localparam int          MIN_FRAME      = 60;   // Padded length without FCS
  localparam int          HDR_LEN        = 42;   // Eth+ARP body, or Eth+IPv4+UDP headers
  localparam int          MAX_PAYLOAD    = 32;   // UDP payload limit
  localparam int          PAYLOAD_LEN_W  = 6;
  localparam logic [15:0] ETHERTYPE_ARP  = 16'h0806;
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_TTL         = 8'd64;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

endpackage
